//--- rtl/spu_rf_pkg.sv
package spu_rf_pkg;

  localparam int data_w = 128;
  localparam int addr_w = 7;
  localparam int num_regs = 128;

  // three operands per pipe, two pipes
  localparam int num_rd_ports = 6;

  // in-flight results come from stages 2..7 of each pipe
  localparam int fwd_first_stage = 2;
  localparam int num_fwd_stages = 6;

  typedef logic [addr_w-1:0] reg_addr_t;
  typedef logic [data_w-1:0] reg_data_t;

  // decoded fields handed on to the execute stage
  typedef struct packed {
    logic [6:0]  instr_id;
    logic [6:0]  reg_dst;
    logic [2:0]  unit_id;
    logic [3:0]  latency;
    logic        reg_wr;
    logic [6:0]  imm7;
    logic [9:0]  imm10;
    logic [15:0] imm16;
    logic [17:0] imm18;
  } instr_t;

  typedef struct packed {
    reg_addr_t ra;
    reg_addr_t rb;
    reg_addr_t rc;
  } src_addr_t;

  typedef struct packed {
    reg_data_t ra;
    reg_data_t rb;
    reg_data_t rc;
  } operands_t;

  typedef struct packed {
    logic      wr;
    reg_addr_t dst;
    reg_data_t result;
  } fwd_entry_t;

  // index 0 is the youngest stage
  typedef fwd_entry_t [num_fwd_stages-1:0] fwd_bus_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    reg_data_t data;
  } wr_port_t;

  typedef enum logic [6:0] {
    op_lnop = 7'd85,
    op_nop  = 7'd86
  } flush_op_e;

endpackage

//--- rtl/spu_reg_file.sv
module spu_reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  spu_rf_pkg::wr_port_t  wr_port_1,
  input  spu_rf_pkg::wr_port_t  wr_port_2,
  input  spu_rf_pkg::reg_addr_t rd_addr [spu_rf_pkg::num_rd_ports],
  output spu_rf_pkg::reg_data_t rd_data [spu_rf_pkg::num_rd_ports]
);

  spu_rf_pkg::reg_data_t regs [spu_rf_pkg::num_regs];

  // both ports land at the same edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < spu_rf_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_port_1.en) begin
        regs[wr_port_1.addr] <= wr_port_1.data;
      end
      if (wr_port_2.en) begin
        regs[wr_port_2.addr] <= wr_port_2.data;
      end
    end
  end

  // read ports see the array before this edge's writes
  for (genvar p = 0; p < spu_rf_pkg::num_rd_ports; p++) begin : g_rd
    assign rd_data[p] = regs[rd_addr[p]];
  end

  // the two pipes never retire to one register in the same cycle
  a_no_dual_write: assert property (
    @(posedge clk) disable iff (rst)
    !(wr_port_1.en && wr_port_2.en && (wr_port_1.addr == wr_port_2.addr))
  ) else $error("both write ports target register %0d", wr_port_1.addr);

endmodule

//--- rtl/spu_fwd_select.sv
module spu_fwd_select (
  input  spu_rf_pkg::reg_addr_t src,
  input  spu_rf_pkg::fwd_bus_t  own_fwd,
  input  spu_rf_pkg::fwd_bus_t  other_fwd,
  input  spu_rf_pkg::reg_data_t rf_data,
  output spu_rf_pkg::reg_data_t data
);

  logic [spu_rf_pkg::num_fwd_stages-1:0] own_hit;
  logic [spu_rf_pkg::num_fwd_stages-1:0] other_hit;

  // one comparator per in-flight entry, twelve in all
  for (genvar i = 0; i < spu_rf_pkg::num_fwd_stages; i++) begin : g_cmp
    assign own_hit[i]   = own_fwd[i].wr && (own_fwd[i].dst == src);
    assign other_hit[i] = other_fwd[i].wr && (other_fwd[i].dst == src);
  end

  // walk from stage 7 down to stage 2, so a younger hit overrides an older one;
  // inside a stage the own pipe is checked last and therefore wins
  always_comb begin
    data = rf_data;
    for (int s = spu_rf_pkg::fwd_first_stage + spu_rf_pkg::num_fwd_stages - 1;
         s >= spu_rf_pkg::fwd_first_stage;
         s--) begin
      if (other_hit[s - spu_rf_pkg::fwd_first_stage]) begin
        data = other_fwd[s - spu_rf_pkg::fwd_first_stage].result;
      end
      if (own_hit[s - spu_rf_pkg::fwd_first_stage]) begin
        data = own_fwd[s - spu_rf_pkg::fwd_first_stage].result;
      end
    end
  end

endmodule

//--- rtl/spu_operand_fetch.sv
module spu_operand_fetch #(
  parameter spu_rf_pkg::flush_op_e flush_op = spu_rf_pkg::op_nop
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  spu_rf_pkg::instr_t    instr,
  input  spu_rf_pkg::src_addr_t src,
  input  spu_rf_pkg::operands_t rf_data,
  input  spu_rf_pkg::fwd_bus_t  own_fwd,
  input  spu_rf_pkg::fwd_bus_t  other_fwd,
  output spu_rf_pkg::instr_t    out_instr,
  output spu_rf_pkg::operands_t opnd
);

  spu_rf_pkg::reg_data_t sel_ra;
  spu_rf_pkg::reg_data_t sel_rb;
  spu_rf_pkg::reg_data_t sel_rc;

  spu_fwd_select i_sel_ra (
    .src       (src.ra),
    .own_fwd   (own_fwd),
    .other_fwd (other_fwd),
    .rf_data   (rf_data.ra),
    .data      (sel_ra)
  );

  spu_fwd_select i_sel_rb (
    .src       (src.rb),
    .own_fwd   (own_fwd),
    .other_fwd (other_fwd),
    .rf_data   (rf_data.rb),
    .data      (sel_rb)
  );

  spu_fwd_select i_sel_rc (
    .src       (src.rc),
    .own_fwd   (own_fwd),
    .other_fwd (other_fwd),
    .rf_data   (rf_data.rc),
    .data      (sel_rc)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_instr <= '0;
      opnd      <= '0;
    end else if (flush) begin
      // bubble for this pipe, nothing gets written back
      out_instr          <= '0;
      out_instr.instr_id <= flush_op;
      opnd               <= '0;
    end else begin
      out_instr <= instr;
      opnd.ra   <= sel_ra;
      opnd.rb   <= sel_rb;
      opnd.rc   <= sel_rc;
    end
  end

  // a flushed slot must not retire a result downstream
  a_flush_bubble: assert property (
    @(posedge clk) disable iff (rst)
    flush |=> (!out_instr.reg_wr && (out_instr.instr_id == flush_op))
  ) else $error("flushed slot still carries a register write");

endmodule

//--- rtl/spu_rf_stage.sv
module spu_rf_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  spu_rf_pkg::instr_t    instr_even,
  input  spu_rf_pkg::instr_t    instr_odd,
  input  spu_rf_pkg::src_addr_t src_even,
  input  spu_rf_pkg::src_addr_t src_odd,
  input  spu_rf_pkg::wr_port_t  wr_port_1,
  input  spu_rf_pkg::wr_port_t  wr_port_2,
  input  spu_rf_pkg::fwd_bus_t  fwd_even,
  input  spu_rf_pkg::fwd_bus_t  fwd_odd,
  output spu_rf_pkg::instr_t    out_instr_even,
  output spu_rf_pkg::instr_t    out_instr_odd,
  output spu_rf_pkg::operands_t opnd_even,
  output spu_rf_pkg::operands_t opnd_odd
);

  spu_rf_pkg::reg_addr_t rd_addr [spu_rf_pkg::num_rd_ports];
  spu_rf_pkg::reg_data_t rd_data [spu_rf_pkg::num_rd_ports];
  spu_rf_pkg::operands_t rf_even;
  spu_rf_pkg::operands_t rf_odd;

  // ports 0..2 serve the even pipe, 3..5 the odd pipe
  assign rd_addr[0] = src_even.ra;
  assign rd_addr[1] = src_even.rb;
  assign rd_addr[2] = src_even.rc;
  assign rd_addr[3] = src_odd.ra;
  assign rd_addr[4] = src_odd.rb;
  assign rd_addr[5] = src_odd.rc;

  assign rf_even = '{ra: rd_data[0], rb: rd_data[1], rc: rd_data[2]};
  assign rf_odd  = '{ra: rd_data[3], rb: rd_data[4], rc: rd_data[5]};

  spu_reg_file i_rf (
    .clk       (clk),
    .rst       (rst),
    .wr_port_1 (wr_port_1),
    .wr_port_2 (wr_port_2),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  spu_operand_fetch #(
    .flush_op (spu_rf_pkg::op_nop)
  ) i_fetch_even (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .instr     (instr_even),
    .src       (src_even),
    .rf_data   (rf_even),
    .own_fwd   (fwd_even),
    .other_fwd (fwd_odd),
    .out_instr (out_instr_even),
    .opnd      (opnd_even)
  );

  spu_operand_fetch #(
    .flush_op (spu_rf_pkg::op_lnop)
  ) i_fetch_odd (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .instr     (instr_odd),
    .src       (src_odd),
    .rf_data   (rf_odd),
    .own_fwd   (fwd_odd),
    .other_fwd (fwd_even),
    .out_instr (out_instr_odd),
    .opnd      (opnd_odd)
  );

endmodule

//--- tb/spu_rf_cases.svh
`ifndef SPU_RF_CASES_SVH
`define SPU_RF_CASES_SVH

// one applied row and the outputs expected one cycle later
typedef struct {
  string                 name;
  logic                  flush;
  spu_rf_pkg::wr_port_t  wr1;
  spu_rf_pkg::wr_port_t  wr2;
  spu_rf_pkg::instr_t    instr_even;
  spu_rf_pkg::instr_t    instr_odd;
  spu_rf_pkg::src_addr_t src_even;
  spu_rf_pkg::src_addr_t src_odd;
  spu_rf_pkg::fwd_bus_t  fwd_even;
  spu_rf_pkg::fwd_bus_t  fwd_odd;
  spu_rf_pkg::instr_t    exp_instr_even;
  spu_rf_pkg::instr_t    exp_instr_odd;
  spu_rf_pkg::operands_t exp_even;
  spu_rf_pkg::operands_t exp_odd;
} row_t;

localparam spu_rf_pkg::reg_data_t val_a = {16{8'ha1}};
localparam spu_rf_pkg::reg_data_t val_b = {16{8'hb2}};
localparam spu_rf_pkg::reg_data_t val_c = {16{8'hc3}};
localparam spu_rf_pkg::reg_data_t val_d = {16{8'hd4}};
localparam spu_rf_pkg::reg_data_t val_e = {16{8'he5}};
localparam spu_rf_pkg::reg_data_t val_f = {16{8'hf6}};
localparam spu_rf_pkg::reg_data_t val_g = {16{8'h17}};
localparam spu_rf_pkg::reg_data_t val_h = {16{8'h28}};
localparam spu_rf_pkg::reg_data_t val_j = {16{8'h39}};
localparam spu_rf_pkg::reg_data_t val_k = {16{8'h4a}};
localparam spu_rf_pkg::reg_data_t val_l = {16{8'h5b}};
localparam spu_rf_pkg::reg_data_t val_m = {16{8'h6c}};

row_t rows[$];
row_t r;

// expected register contents, updated as rows are queued
spu_rf_pkg::reg_data_t shadow [spu_rf_pkg::num_regs];

function automatic spu_rf_pkg::wr_port_t wport(input spu_rf_pkg::reg_addr_t addr,
                                               input spu_rf_pkg::reg_data_t data);
  spu_rf_pkg::wr_port_t p;
  p.en   = 1'b1;
  p.addr = addr;
  p.data = data;
  return p;
endfunction

function automatic spu_rf_pkg::src_addr_t srcs(input spu_rf_pkg::reg_addr_t ra,
                                               input spu_rf_pkg::reg_addr_t rb,
                                               input spu_rf_pkg::reg_addr_t rc);
  spu_rf_pkg::src_addr_t s;
  s.ra = ra;
  s.rb = rb;
  s.rc = rc;
  return s;
endfunction

function automatic spu_rf_pkg::operands_t opnds(input spu_rf_pkg::reg_data_t ra,
                                                input spu_rf_pkg::reg_data_t rb,
                                                input spu_rf_pkg::reg_data_t rc);
  spu_rf_pkg::operands_t o;
  o.ra = ra;
  o.rb = rb;
  o.rc = rc;
  return o;
endfunction

// puts one in-flight result at pipeline stage 2..7
function automatic spu_rf_pkg::fwd_bus_t at_stage(input spu_rf_pkg::fwd_bus_t bus,
                                                  input int stage,
                                                  input logic wr,
                                                  input spu_rf_pkg::reg_addr_t dst,
                                                  input spu_rf_pkg::reg_data_t result);
  spu_rf_pkg::fwd_bus_t b;
  b = bus;
  b[stage - spu_rf_pkg::fwd_first_stage].wr     = wr;
  b[stage - spu_rf_pkg::fwd_first_stage].dst    = dst;
  b[stage - spu_rf_pkg::fwd_first_stage].result = result;
  return b;
endfunction

function automatic spu_rf_pkg::instr_t make_instr(input logic [6:0] id,
                                                  input spu_rf_pkg::reg_addr_t dst);
  spu_rf_pkg::instr_t i;
  i          = '0;
  i.instr_id = id;
  i.reg_dst  = dst;
  i.unit_id  = 3'd2;
  i.latency  = 4'd6;
  i.reg_wr   = 1'b1;
  i.imm10    = {3'd0, id};
  return i;
endfunction

// youngest stage first, own pipe before the other pipe, else the register file
function automatic spu_rf_pkg::reg_data_t resolve(input spu_rf_pkg::reg_addr_t addr,
                                                  input spu_rf_pkg::fwd_bus_t own,
                                                  input spu_rf_pkg::fwd_bus_t other);
  for (int i = 0; i < spu_rf_pkg::num_fwd_stages; i++) begin
    if (own[i].wr && own[i].dst == addr) begin
      return own[i].result;
    end
    if (other[i].wr && other[i].dst == addr) begin
      return other[i].result;
    end
  end
  return shadow[addr];
endfunction

function automatic spu_rf_pkg::reg_data_t rand_data();
  return {$random(seed), $random(seed), $random(seed), $random(seed)};
endfunction

// random addresses stay in 8..15 so that hits are frequent
function automatic spu_rf_pkg::reg_addr_t pick_addr(input logic [2:0] sel);
  return 7'd8 + {4'd0, sel};
endfunction

task automatic new_row(input string name);
  r.name           = name;
  r.flush          = 1'b0;
  r.wr1            = '0;
  r.wr2            = '0;
  r.instr_even     = make_instr(7'(2 * rows.size() + 1), 7'd100);
  r.instr_odd      = make_instr(7'(2 * rows.size() + 2), 7'd101);
  r.src_even       = '0;
  r.src_odd        = '0;
  r.fwd_even       = '0;
  r.fwd_odd        = '0;
  r.exp_instr_even = r.instr_even;
  r.exp_instr_odd  = r.instr_odd;
  r.exp_even       = '0;
  r.exp_odd        = '0;
endtask

task automatic push_row();
  rows.push_back(r);
  if (r.wr1.en) begin
    shadow[r.wr1.addr] = r.wr1.data;
  end
  if (r.wr2.en) begin
    shadow[r.wr2.addr] = r.wr2.data;
  end
endtask

task automatic random_row(input string name);
  logic [31:0] w;
  logic [95:0] d;
  new_row(name);
  d = {$random(seed), $random(seed), $random(seed)};
  r.instr_even = d[$bits(spu_rf_pkg::instr_t)-1:0];
  d = {$random(seed), $random(seed), $random(seed)};
  r.instr_odd = d[$bits(spu_rf_pkg::instr_t)-1:0];
  w = $random(seed);
  r.wr1 = wport(pick_addr(w[2:0]), rand_data());
  r.wr1.en = w[3];
  // neighbouring address keeps the two ports apart
  r.wr2 = wport(r.wr1.addr ^ 7'd1, rand_data());
  r.wr2.en = w[4];
  r.src_even = srcs(pick_addr(w[7:5]), pick_addr(w[10:8]), pick_addr(w[13:11]));
  r.src_odd  = srcs(pick_addr(w[16:14]), pick_addr(w[19:17]), pick_addr(w[22:20]));
  for (int s = 2; s <= 7; s++) begin
    w = $random(seed);
    r.fwd_even = at_stage(r.fwd_even, s, w[0], pick_addr(w[3:1]), rand_data());
    r.fwd_odd  = at_stage(r.fwd_odd, s, w[4], pick_addr(w[7:5]), rand_data());
  end
  r.exp_instr_even = r.instr_even;
  r.exp_instr_odd  = r.instr_odd;
  r.exp_even = opnds(resolve(r.src_even.ra, r.fwd_even, r.fwd_odd),
                     resolve(r.src_even.rb, r.fwd_even, r.fwd_odd),
                     resolve(r.src_even.rc, r.fwd_even, r.fwd_odd));
  r.exp_odd  = opnds(resolve(r.src_odd.ra, r.fwd_odd, r.fwd_even),
                     resolve(r.src_odd.rb, r.fwd_odd, r.fwd_even),
                     resolve(r.src_odd.rc, r.fwd_odd, r.fwd_even));
  push_row();
endtask

task automatic build_cases();
  foreach (shadow[i]) begin
    shadow[i] = '0;
  end

  // writes land at the edge, so this row still reads zeros
  new_row("rf_write_same_row");
  r.wr1      = wport(7'd10, val_a);
  r.wr2      = wport(7'd20, val_b);
  r.src_even = srcs(7'd10, 7'd20, 7'd10);
  r.src_odd  = srcs(7'd20, 7'd10, 7'd20);
  push_row();

  new_row("rf_read_back");
  r.src_even = srcs(7'd10, 7'd20, 7'd10);
  r.src_odd  = srcs(7'd20, 7'd10, 7'd20);
  r.exp_even = opnds(val_a, val_b, val_a);
  r.exp_odd  = opnds(val_b, val_a, val_b);
  push_row();

  new_row("fwd_younger_own_stage");
  r.fwd_even = at_stage(r.fwd_even, 3, 1'b1, 7'd10, val_c);
  r.fwd_even = at_stage(r.fwd_even, 5, 1'b1, 7'd10, val_d);
  r.src_even = srcs(7'd10, 7'd20, 7'd30);
  r.src_odd  = srcs(7'd20, 7'd30, 7'd20);
  r.exp_even = opnds(val_c, val_b, '0);
  r.exp_odd  = opnds(val_b, '0, val_b);
  push_row();

  new_row("fwd_wr_low_ignored");
  r.fwd_even = at_stage(r.fwd_even, 2, 1'b0, 7'd20, val_e);
  r.fwd_odd  = at_stage(r.fwd_odd, 2, 1'b0, 7'd10, val_e);
  r.src_even = srcs(7'd20, 7'd10, 7'd20);
  r.src_odd  = srcs(7'd10, 7'd20, 7'd10);
  r.exp_even = opnds(val_b, val_a, val_b);
  r.exp_odd  = opnds(val_a, val_b, val_a);
  push_row();

  new_row("fwd_other_pipe_only");
  r.fwd_odd  = at_stage(r.fwd_odd, 4, 1'b1, 7'd10, val_f);
  r.src_even = srcs(7'd10, 7'd20, 7'd10);
  r.src_odd  = srcs(7'd20, 7'd10, 7'd30);
  r.exp_even = opnds(val_f, val_b, val_f);
  r.exp_odd  = opnds(val_b, val_f, '0);
  push_row();

  new_row("fwd_same_stage_own_wins");
  r.fwd_even = at_stage(r.fwd_even, 3, 1'b1, 7'd10, val_g);
  r.fwd_odd  = at_stage(r.fwd_odd, 3, 1'b1, 7'd10, val_h);
  r.src_even = srcs(7'd10, 7'd20, 7'd10);
  r.src_odd  = srcs(7'd10, 7'd10, 7'd20);
  r.exp_even = opnds(val_g, val_b, val_g);
  r.exp_odd  = opnds(val_h, val_h, val_b);
  push_row();

  new_row("fwd_younger_other_wins");
  r.fwd_even = at_stage(r.fwd_even, 6, 1'b1, 7'd20, val_j);
  r.fwd_odd  = at_stage(r.fwd_odd, 2, 1'b1, 7'd20, val_k);
  r.src_even = srcs(7'd20, 7'd10, 7'd20);
  r.src_odd  = srcs(7'd20, 7'd20, 7'd10);
  r.exp_even = opnds(val_k, val_a, val_k);
  r.exp_odd  = opnds(val_k, val_k, val_a);
  push_row();

  new_row("flush_with_write");
  r.flush    = 1'b1;
  r.wr1      = wport(7'd40, val_l);
  r.wr2      = wport(7'd41, val_m);
  r.fwd_even = at_stage(r.fwd_even, 2, 1'b1, 7'd10, val_c);
  r.src_even = srcs(7'd10, 7'd20, 7'd10);
  r.src_odd  = srcs(7'd20, 7'd10, 7'd20);
  r.exp_instr_even          = '0;
  r.exp_instr_even.instr_id = 7'd86;
  r.exp_instr_odd           = '0;
  r.exp_instr_odd.instr_id  = 7'd85;
  push_row();

  new_row("read_after_flush");
  r.src_even = srcs(7'd40, 7'd41, 7'd10);
  r.src_odd  = srcs(7'd41, 7'd40, 7'd20);
  r.exp_even = opnds(val_l, val_m, val_a);
  r.exp_odd  = opnds(val_m, val_l, val_b);
  push_row();

  for (int n = 1; n <= 8; n++) begin
    random_row($sformatf("random_%0d", n));
  end
endtask

`endif

//--- tb/tb_spu_rf_stage.sv
module tb_spu_rf_stage;

  logic                  clk;
  logic                  rst;
  logic                  flush;
  spu_rf_pkg::instr_t    instr_even;
  spu_rf_pkg::instr_t    instr_odd;
  spu_rf_pkg::src_addr_t src_even;
  spu_rf_pkg::src_addr_t src_odd;
  spu_rf_pkg::wr_port_t  wr_port_1;
  spu_rf_pkg::wr_port_t  wr_port_2;
  spu_rf_pkg::fwd_bus_t  fwd_even;
  spu_rf_pkg::fwd_bus_t  fwd_odd;
  spu_rf_pkg::instr_t    out_instr_even;
  spu_rf_pkg::instr_t    out_instr_odd;
  spu_rf_pkg::operands_t opnd_even;
  spu_rf_pkg::operands_t opnd_odd;

  int seed;
  int cycles;
  int limit;
  int pass_count;
  int fail_count;
  int row_errs;

  `include "spu_rf_cases.svh"

  spu_rf_stage i_dut (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .instr_even     (instr_even),
    .instr_odd      (instr_odd),
    .src_even       (src_even),
    .src_odd        (src_odd),
    .wr_port_1      (wr_port_1),
    .wr_port_2      (wr_port_2),
    .fwd_even       (fwd_even),
    .fwd_odd        (fwd_odd),
    .out_instr_even (out_instr_even),
    .out_instr_odd  (out_instr_odd),
    .opnd_even      (opnd_even),
    .opnd_odd       (opnd_odd)
  );

  always #4 clk = ~clk;

  // limit stays 0 until the table length is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic check_instr(input string name, input string sig,
                             input spu_rf_pkg::instr_t exp, input spu_rf_pkg::instr_t act);
    assert (act === exp) else begin
      $display("error %s in %s: expected %h, got %h", sig, name, exp, act);
      row_errs++;
    end
  endtask

  task automatic check_value(input string name, input string sig,
                             input spu_rf_pkg::reg_data_t exp,
                             input spu_rf_pkg::reg_data_t act);
    assert (act === exp) else begin
      $display("error %s in %s: expected %h, got %h", sig, name, exp, act);
      row_errs++;
    end
  endtask

  task automatic check_outputs(input string name,
                               input spu_rf_pkg::instr_t exp_ie,
                               input spu_rf_pkg::instr_t exp_io,
                               input spu_rf_pkg::operands_t exp_oe,
                               input spu_rf_pkg::operands_t exp_oo);
    check_instr(name, "out_instr_even", exp_ie, out_instr_even);
    check_instr(name, "out_instr_odd", exp_io, out_instr_odd);
    check_value(name, "opnd_even.ra", exp_oe.ra, opnd_even.ra);
    check_value(name, "opnd_even.rb", exp_oe.rb, opnd_even.rb);
    check_value(name, "opnd_even.rc", exp_oe.rc, opnd_even.rc);
    check_value(name, "opnd_odd.ra", exp_oo.ra, opnd_odd.ra);
    check_value(name, "opnd_odd.rb", exp_oo.rb, opnd_odd.rb);
    check_value(name, "opnd_odd.rc", exp_oo.rc, opnd_odd.rc);
  endtask

  task automatic report(input string name);
    if (row_errs == 0) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: %0d mismatches", name, row_errs);
    end
    row_errs = 0;
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    flush      = 1'b0;
    // busy inputs while reset is held, the outputs must stay cleared anyway
    instr_even = make_instr(7'd3, 7'd50);
    instr_odd  = make_instr(7'd4, 7'd51);
    src_even   = '0;
    src_odd    = '0;
    wr_port_1  = '0;
    wr_port_2  = '0;
    fwd_even   = at_stage('0, 2, 1'b1, 7'd0, val_a);
    fwd_odd    = at_stage('0, 2, 1'b1, 7'd0, val_b);
    seed       = 66;
    cycles     = 0;
    limit      = 0;
    pass_count = 0;
    fail_count = 0;
    row_errs   = 0;

    build_cases();
    limit = 10 + 2 * rows.size() + 20;

    // outputs stay cleared while reset is held and one edge after it drops
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_outputs("reset", '0, '0, '0, '0);
    repeat (5) @(posedge clk);
    rst        <= 1'b0;
    instr_even <= '0;
    instr_odd  <= '0;
    fwd_even   <= '0;
    fwd_odd    <= '0;
    @(posedge clk);
    @(negedge clk);
    check_outputs("reset", '0, '0, '0, '0);
    report("reset");

    foreach (rows[k]) begin
      @(posedge clk);
      flush      <= rows[k].flush;
      wr_port_1  <= rows[k].wr1;
      wr_port_2  <= rows[k].wr2;
      instr_even <= rows[k].instr_even;
      instr_odd  <= rows[k].instr_odd;
      src_even   <= rows[k].src_even;
      src_odd    <= rows[k].src_odd;
      fwd_even   <= rows[k].fwd_even;
      fwd_odd    <= rows[k].fwd_odd;
      // one cycle of latency, sampled mid-cycle
      @(posedge clk);
      @(negedge clk);
      check_outputs(rows[k].name, rows[k].exp_instr_even, rows[k].exp_instr_odd,
                    rows[k].exp_even, rows[k].exp_odd);
      report(rows[k].name);
    end

    $display("summary: %0d of %0d tests ok, %0d with mismatches",
             pass_count, pass_count + fail_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+tb
rtl/spu_rf_pkg.sv
rtl/spu_reg_file.sv
rtl/spu_fwd_select.sv
rtl/spu_operand_fetch.sv
rtl/spu_rf_stage.sv
tb/tb_spu_rf_stage.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_spu_rf_stage

./obj_dir/Vtb_spu_rf_stage | tee sim.log

# the run counts as passed only if the testbench printed its pass line
grep -qx "TESTS PASSED" sim.log
